/* source/isa_pkg.sv */
package isa_pkg;

	// Architectural sizes.
	localparam int XLEN   = 16;
	localparam int NREG   = 8;
	localparam int REG_AW = 3;
	localparam int MEM_AW = 8;
	localparam int OPC_W  = 5;

	localparam logic [REG_AW-1:0] LINK_REG = 3'd7;

	// ********************
	// Instruction fields.
	// ********************
	localparam int OP_HI    = 15;
	localparam int OP_LO    = 11;
	localparam int RS_HI    = 10;
	localparam int RS_LO    = 8;
	localparam int RT_HI    = 7;
	localparam int RT_LO    = 5;
	localparam int RD_HI    = 4;
	localparam int RD_LO    = 2;
	localparam int FUNCT_HI = 1;
	localparam int FUNCT_LO = 0;
	localparam int IMM5_W   = 5;
	localparam int IMM8_W   = 8;
	localparam int DISP_W   = 11;

	typedef enum logic [OPC_W-1:0] {
		OP_HALT,  OP_NOP,   OP_SIIC,  OP_RTI,
		OP_J,     OP_JR,    OP_JAL,   OP_JALR,
		OP_ADDI,  OP_SUBI,  OP_XORI,  OP_ANDNI,
		OP_BEQZ,  OP_BNEZ,  OP_BLTZ,  OP_BGEZ,
		OP_ST,    OP_LD,    OP_SLBI,  OP_STU,
		OP_ROLI,  OP_SLLI,  OP_RORI,  OP_SRLI,
		OP_LBI,   OP_BTR,   OP_ALU_SHIFT, OP_ALU_ARITH,
		OP_SEQ,   OP_SLT,   OP_SLE,   OP_SCO
	} opcode_e;

endpackage

/* source/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_ANDN,
		ALU_ROL,
		ALU_SLL,
		ALU_ROR,
		ALU_SRL,
		ALU_SEQ,
		ALU_SLT,
		ALU_SLE,
		ALU_SCO,
		ALU_BTR,
		ALU_SLBI,
		ALU_PASS_B
	} alu_op_e;

	// Second ALU operand.
	typedef enum logic [2:0] {
		SRC_RT,
		SRC_SEXT5,
		SRC_ZEXT5,
		SRC_SEXT8,
		SRC_ZEXT8
	} alu_src_e;

	typedef enum logic [1:0] {DST_RD, DST_RT, DST_RS, DST_LINK} reg_dst_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC2, WB_IMM8} wb_sel_e;

	// Next-PC kind.
	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQZ,
		BR_NEZ,
		BR_LTZ,
		BR_GEZ,
		BR_JUMP,
		BR_JREG
	} branch_e;

endpackage

/* source/control.sv */
`timescale 1ns/1ps

module control import isa_pkg::*, ctrl_pkg::*; (
	input  opcode_e    i_opcode,
	input  logic [1:0] i_funct,
	output alu_op_e    o_alu_op,
	output alu_src_e   o_alu_src,
	output reg_dst_e   o_reg_dst,
	output wb_sel_e    o_wb_sel,
	output logic       o_reg_write,
	output logic       o_mem_read,
	output logic       o_mem_write,
	output branch_e    o_branch,
	output logic       o_halt
);

	function automatic alu_op_e arith_op(input logic [1:0] sel);
		case (sel)
			2'b00:   return ALU_ADD;
			2'b01:   return ALU_SUB;
			2'b10:   return ALU_XOR;
			default: return ALU_ANDN;
		endcase
	endfunction

	function automatic alu_op_e shift_op(input logic [1:0] sel);
		case (sel)
			2'b00:   return ALU_ROL;
			2'b01:   return ALU_SLL;
			2'b10:   return ALU_ROR;
			default: return ALU_SRL;
		endcase
	endfunction

	always_comb begin
		o_alu_op    = ALU_PASS_B;
		o_alu_src   = SRC_RT;
		o_reg_dst   = DST_RD;
		o_wb_sel    = WB_ALU;
		o_reg_write = 1'b0;
		o_mem_read  = 1'b0;
		o_mem_write = 1'b0;
		o_branch    = BR_NONE;
		o_halt      = 1'b0;

		case (i_opcode)
			OP_HALT: begin
				o_halt = 1'b1;
			end

			// siic and rti behave as nop.
			OP_NOP, OP_SIIC, OP_RTI: begin
			end

			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
				o_reg_dst   = DST_RT;
				o_alu_src   = i_opcode[1] ? SRC_ZEXT5 : SRC_SEXT5;
				o_alu_op    = arith_op(i_opcode[1:0]);
				o_reg_write = 1'b1;
			end

			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				o_reg_dst   = DST_RT;
				o_alu_src   = SRC_ZEXT5;
				o_alu_op    = shift_op(i_opcode[1:0]);
				o_reg_write = 1'b1;
			end

			OP_ALU_ARITH: begin
				o_alu_op    = arith_op(i_funct);
				o_reg_write = 1'b1;
			end

			OP_ALU_SHIFT: begin
				o_alu_op    = shift_op(i_funct);
				o_reg_write = 1'b1;
			end

			OP_ST: begin
				o_alu_op    = ALU_ADD;
				o_alu_src   = SRC_SEXT5;
				o_mem_write = 1'b1;
			end

			OP_LD: begin
				o_reg_dst   = DST_RT;
				o_alu_op    = ALU_ADD;
				o_alu_src   = SRC_SEXT5;
				o_wb_sel    = WB_MEM;
				o_mem_read  = 1'b1;
				o_reg_write = 1'b1;
			end

			// Store, then write the address back to the base register.
			OP_STU: begin
				o_reg_dst   = DST_RS;
				o_alu_op    = ALU_ADD;
				o_alu_src   = SRC_SEXT5;
				o_mem_write = 1'b1;
				o_reg_write = 1'b1;
			end

			OP_SLBI: begin
				o_reg_dst   = DST_RS;
				o_alu_op    = ALU_SLBI;
				o_alu_src   = SRC_ZEXT8;
				o_reg_write = 1'b1;
			end

			OP_LBI: begin
				o_reg_dst   = DST_RS;
				o_wb_sel    = WB_IMM8;
				o_reg_write = 1'b1;
			end

			OP_BTR: begin
				o_alu_op    = ALU_BTR;
				o_reg_write = 1'b1;
			end

			OP_SEQ: begin
				o_alu_op    = ALU_SEQ;
				o_reg_write = 1'b1;
			end

			OP_SLT: begin
				o_alu_op    = ALU_SLT;
				o_reg_write = 1'b1;
			end

			OP_SLE: begin
				o_alu_op    = ALU_SLE;
				o_reg_write = 1'b1;
			end

			OP_SCO: begin
				o_alu_op    = ALU_SCO;
				o_reg_write = 1'b1;
			end

			OP_BEQZ: o_branch = BR_EQZ;
			OP_BNEZ: o_branch = BR_NEZ;
			OP_BLTZ: o_branch = BR_LTZ;
			OP_BGEZ: o_branch = BR_GEZ;

			OP_J: begin
				o_branch = BR_JUMP;
			end

			OP_JR: begin
				o_branch  = BR_JREG;
				o_alu_src = SRC_SEXT8;
				o_alu_op  = ALU_ADD;
			end

			OP_JAL: begin
				o_branch    = BR_JUMP;
				o_reg_dst   = DST_LINK;
				o_wb_sel    = WB_PC2;
				o_reg_write = 1'b1;
			end

			OP_JALR: begin
				o_branch    = BR_JREG;
				o_alu_src   = SRC_SEXT8;
				o_alu_op    = ALU_ADD;
				o_reg_dst   = DST_LINK;
				o_wb_sel    = WB_PC2;
				o_reg_write = 1'b1;
			end
		endcase
	end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic [REG_AW-1:0] i_rs_addr,
	input  logic [REG_AW-1:0] i_rt_addr,
	input  logic              i_wr_en,
	input  logic [REG_AW-1:0] i_wr_addr,
	input  logic [XLEN-1:0]   i_wr_data,
	output logic [XLEN-1:0]   o_rs_data,
	output logic [XLEN-1:0]   o_rt_data
);

	logic [XLEN-1:0] regs [NREG];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// Reads have no bypass. A write shows up on the next cycle.
	assign o_rs_data = regs[i_rs_addr];
	assign o_rt_data = regs[i_rt_addr];

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu import isa_pkg::*, ctrl_pkg::*; (
	input  alu_op_e         i_op,
	input  logic [XLEN-1:0] i_a,
	input  logic [XLEN-1:0] i_b,
	output logic [XLEN-1:0] o_result
);

	logic [3:0]        shamt;
	logic [XLEN:0]     sum;
	logic [2*XLEN-1:0] rol_full;
	logic [2*XLEN-1:0] ror_full;
	logic [XLEN-1:0]   rev;
	logic              lt;
	logic              eq;

	assign shamt = i_b[3:0];
	assign sum   = {1'b0, i_a} + {1'b0, i_b};

	// Rotates work on the doubled operand.
	assign rol_full = {i_a, i_a} << shamt;
	assign ror_full = {i_a, i_a} >> shamt;

	assign eq = (i_a == i_b);
	assign lt = ($signed(i_a) < $signed(i_b));

	always_comb begin
		for (int i = 0; i < XLEN; i++) begin
			rev[i] = i_a[XLEN-1-i];
		end
	end

	// ********************
	// Result select.
	// ********************
	always_comb begin
		case (i_op)
			ALU_ADD:  o_result = sum[XLEN-1:0];
			ALU_SUB:  o_result = i_b - i_a;
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_ANDN: o_result = i_a & ~i_b;
			ALU_ROL:  o_result = rol_full[2*XLEN-1:XLEN];
			ALU_SLL:  o_result = i_a << shamt;
			ALU_ROR:  o_result = ror_full[XLEN-1:0];
			ALU_SRL:  o_result = i_a >> shamt;
			ALU_SEQ:  o_result = {{(XLEN-1){1'b0}}, eq};
			ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt};
			ALU_SLE:  o_result = {{(XLEN-1){1'b0}}, lt | eq};
			// carry out of a+b
			ALU_SCO:  o_result = {{(XLEN-1){1'b0}}, sum[XLEN]};
			ALU_BTR:  o_result = rev;
			ALU_SLBI: o_result = (i_a << 8) | {8'h00, i_b[7:0]};
			default:  o_result = i_b;
		endcase
	end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import isa_pkg::*, ctrl_pkg::*; (
	input  branch_e           i_kind,
	input  logic [XLEN-1:0]   i_pc,
	input  logic [XLEN-1:0]   i_rs_data,
	input  logic [IMM8_W-1:0] i_imm8,
	input  logic [DISP_W-1:0] i_disp11,
	output logic [XLEN-1:0]   o_next_pc
);

	logic [XLEN-1:0] pc_plus2;
	logic [XLEN-1:0] imm8_sext;
	logic [XLEN-1:0] disp_sext;
	logic            rs_zero;
	logic            rs_neg;
	logic            taken;

	assign pc_plus2  = i_pc + 16'd2;
	assign imm8_sext = {{(XLEN-IMM8_W){i_imm8[IMM8_W-1]}}, i_imm8};
	assign disp_sext = {{(XLEN-DISP_W){i_disp11[DISP_W-1]}}, i_disp11};

	assign rs_zero = (i_rs_data == '0);
	assign rs_neg  = i_rs_data[XLEN-1];

	always_comb begin
		case (i_kind)
			BR_EQZ:  taken = rs_zero;
			BR_NEZ:  taken = !rs_zero;
			BR_LTZ:  taken = rs_neg;
			BR_GEZ:  taken = !rs_neg;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		o_next_pc = pc_plus2;
		if (i_kind == BR_JUMP) begin
			o_next_pc = pc_plus2 + disp_sext;
		end else if (i_kind == BR_JREG) begin
			o_next_pc = i_rs_data + imm8_sext;
		end else if (taken) begin
			o_next_pc = pc_plus2 + imm8_sext;
		end
	end

endmodule

/* source/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import isa_pkg::*, ctrl_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_load_valid,
	input  logic [MEM_AW-1:0] i_load_addr,
	input  logic [XLEN-1:0]   i_load_data,
	output logic              o_load_ready,
	input  logic              i_start,
	output logic              o_retire_valid,
	input  logic              i_retire_ready,
	output logic [XLEN-1:0]   o_retire_pc,
	output logic              o_wb_en,
	output logic [REG_AW-1:0] o_wb_reg,
	output logic [XLEN-1:0]   o_wb_data,
	output logic              o_mem_we,
	output logic [XLEN-1:0]   o_mem_addr,
	output logic [XLEN-1:0]   o_mem_wdata,
	output logic              o_halt
);

	logic              running;
	logic [XLEN-1:0]   pc;
	logic [XLEN-1:0]   imem [2**MEM_AW];
	logic [XLEN-1:0]   dmem [2**MEM_AW];
	logic [XLEN-1:0]   instr;
	opcode_e           opcode;
	logic [IMM5_W-1:0] imm5;
	logic [IMM8_W-1:0] imm8;
	logic [XLEN-1:0]   imm8_sext;
	logic [XLEN-1:0]   pc_plus2;
	alu_op_e           ctl_alu_op;
	alu_src_e          ctl_alu_src;
	reg_dst_e          ctl_reg_dst;
	wb_sel_e           ctl_wb_sel;
	branch_e           ctl_branch;
	logic              ctl_reg_write;
	logic              ctl_mem_read;
	logic              ctl_mem_write;
	logic              ctl_halt;
	logic [XLEN-1:0]   rs_data;
	logic [XLEN-1:0]   rt_data;
	logic [XLEN-1:0]   alu_b;
	logic [XLEN-1:0]   alu_result;
	logic [XLEN-1:0]   next_pc;
	logic [XLEN-1:0]   mem_rdata;
	logic [MEM_AW-1:0] mem_idx;
	logic [REG_AW-1:0] wb_addr;
	logic [XLEN-1:0]   wb_data;
	logic              commit;

	// Fetch and field split.
	assign instr     = imem[pc[MEM_AW:1]];
	assign opcode    = opcode_e'(instr[OP_HI:OP_LO]);
	assign imm5      = instr[IMM5_W-1:0];
	assign imm8      = instr[IMM8_W-1:0];
	assign imm8_sext = {{(XLEN-IMM8_W){imm8[IMM8_W-1]}}, imm8};
	assign pc_plus2  = pc + 16'd2;

	control control_i (
		.i_opcode   (opcode),
		.i_funct    (instr[FUNCT_HI:FUNCT_LO]),
		.o_alu_op   (ctl_alu_op),
		.o_alu_src  (ctl_alu_src),
		.o_reg_dst  (ctl_reg_dst),
		.o_wb_sel   (ctl_wb_sel),
		.o_reg_write(ctl_reg_write),
		.o_mem_read (ctl_mem_read),
		.o_mem_write(ctl_mem_write),
		.o_branch   (ctl_branch),
		.o_halt     (ctl_halt)
	);

	reg_file reg_file_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_rs_addr(instr[RS_HI:RS_LO]),
		.i_rt_addr(instr[RT_HI:RT_LO]),
		.i_wr_en  (commit && ctl_reg_write),
		.i_wr_addr(wb_addr),
		.i_wr_data(wb_data),
		.o_rs_data(rs_data),
		.o_rt_data(rt_data)
	);

	always_comb begin
		case (ctl_alu_src)
			SRC_SEXT5: alu_b = {{(XLEN-IMM5_W){imm5[IMM5_W-1]}}, imm5};
			SRC_ZEXT5: alu_b = {{(XLEN-IMM5_W){1'b0}}, imm5};
			SRC_SEXT8: alu_b = imm8_sext;
			SRC_ZEXT8: alu_b = {{(XLEN-IMM8_W){1'b0}}, imm8};
			default:   alu_b = rt_data;
		endcase
	end

	alu alu_i (
		.i_op    (ctl_alu_op),
		.i_a     (rs_data),
		.i_b     (alu_b),
		.o_result(alu_result)
	);

	branch_unit branch_unit_i (
		.i_kind   (ctl_branch),
		.i_pc     (pc),
		.i_rs_data(rs_data),
		.i_imm8   (imm8),
		.i_disp11 (instr[DISP_W-1:0]),
		.o_next_pc(next_pc)
	);

	// Word index from the byte address.
	assign mem_idx   = alu_result[MEM_AW:1];
	assign mem_rdata = ctl_mem_read ? dmem[mem_idx] : '0;

	always_comb begin
		case (ctl_reg_dst)
			DST_RT:   wb_addr = instr[RT_HI:RT_LO];
			DST_RS:   wb_addr = instr[RS_HI:RS_LO];
			DST_LINK: wb_addr = LINK_REG;
			default:  wb_addr = instr[RD_HI:RD_LO];
		endcase
	end

	always_comb begin
		case (ctl_wb_sel)
			WB_MEM:  wb_data = mem_rdata;
			WB_PC2:  wb_data = pc_plus2;
			WB_IMM8: wb_data = imm8_sext;
			default: wb_data = alu_result;
		endcase
	end

	// ********************
	// Run state and PC.
	// ********************
	assign commit = running && i_retire_ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			running <= 1'b0;
			pc      <= '0;
		end else if (!running) begin
			if (i_start) begin
				running <= 1'b1;
				pc      <= '0;
			end
		end else if (i_retire_ready) begin
			pc <= next_pc;
			if (ctl_halt) begin
				running <= 1'b0;
			end
		end
	end

	// Program load only while idle.
	always_ff @(posedge i_clk) begin
		if (i_load_valid && o_load_ready) begin
			imem[i_load_addr] <= i_load_data;
		end
	end

	always_ff @(posedge i_clk) begin
		if (commit && ctl_mem_write) begin
			dmem[mem_idx] <= rt_data;
		end
	end

	assign o_load_ready   = !running;
	assign o_retire_valid = running;
	assign o_retire_pc    = pc;
	assign o_wb_en        = running && ctl_reg_write;
	assign o_wb_reg       = wb_addr;
	assign o_wb_data      = wb_data;
	assign o_mem_we       = running && ctl_mem_write;
	assign o_mem_addr     = alu_result;
	assign o_mem_wdata    = rt_data;
	assign o_halt         = running && ctl_halt;

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk
);

	localparam time HALF_PERIOD = 20ns;

	initial begin
		o_clk = 1'b0;
		forever begin
			#HALF_PERIOD o_clk = ~o_clk;
		end
	end

endmodule

/* verif/cpu_sva.sv */
`timescale 1ns/1ps

module cpu_sva (
	input logic        i_clk,
	input logic        i_rst_n,
	input logic        i_start,
	input logic        i_retire_valid,
	input logic        i_retire_ready,
	input logic        i_load_ready,
	input logic        i_halt,
	input logic [15:0] i_retire_pc,
	input logic        i_wb_en,
	input logic [2:0]  i_wb_reg,
	input logic [15:0] i_wb_data,
	input logic        i_mem_we,
	input logic [15:0] i_mem_addr,
	input logic [15:0] i_mem_wdata
);

	// Stalled retire beat keeps all of its fields.
	a_hold_fields: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_retire_valid && !i_retire_ready) |=> $stable({i_retire_pc, i_wb_en, i_wb_reg,
			i_wb_data, i_mem_we, i_mem_addr, i_mem_wdata, i_halt}))
		else $error("retire fields changed under back-pressure");

	// An accepted start runs from pc 0 with the load port closed.
	a_start_runs: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_start && i_load_ready) |=>
			(i_retire_valid && !i_load_ready && i_retire_pc == 16'd0))
		else $error("start was not followed by a run from pc 0");

	a_halt_stops: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_retire_valid && i_retire_ready && i_halt) |=> !i_retire_valid)
		else $error("retire valid still high after a committed halt");

endmodule

bind cpu_core cpu_sva sva_i (
	.i_clk         (i_clk),
	.i_rst_n       (i_rst_n),
	.i_start       (i_start),
	.i_retire_valid(o_retire_valid),
	.i_retire_ready(i_retire_ready),
	.i_load_ready  (o_load_ready),
	.i_halt        (o_halt),
	.i_retire_pc   (o_retire_pc),
	.i_wb_en       (o_wb_en),
	.i_wb_reg      (o_wb_reg),
	.i_wb_data     (o_wb_data),
	.i_mem_we      (o_mem_we),
	.i_mem_addr    (o_mem_addr),
	.i_mem_wdata   (o_mem_wdata)
);

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import isa_pkg::*; ();

	localparam int  TOTAL_WORDS = 120;
	localparam int  WATCHDOG_CYCLES = 4 * TOTAL_WORDS + 1000;
	localparam time CLK_PERIOD = 40ns;
	localparam int  RAND_LEN = 40;

	typedef struct packed {
		logic [15:0] pc;
		logic        wb_en;
		logic [2:0]  wb_reg;
		logic [15:0] wb_data;
		logic        mem_we;
		logic [15:0] mem_addr;
		logic [15:0] mem_wdata;
		logic        halt;
		logic [15:0] next_pc;
	} retire_t;

	logic        clk;
	logic        rst_n;
	logic        i_load_valid;
	logic [7:0]  i_load_addr;
	logic [15:0] i_load_data;
	logic        o_load_ready;
	logic        i_start;
	logic        o_retire_valid;
	logic        i_retire_ready;
	logic [15:0] o_retire_pc;
	logic        o_wb_en;
	logic [2:0]  o_wb_reg;
	logic [15:0] o_wb_data;
	logic        o_mem_we;
	logic [15:0] o_mem_addr;
	logic [15:0] o_mem_wdata;
	logic        o_halt;

	// Architectural model state.
	logic [15:0] m_regs [8];
	logic [15:0] m_dmem [256];
	logic [15:0] m_imem [256];
	logic [15:0] m_pc;
	logic        m_active;

	logic [15:0] prog [$];
	logic [31:0] rng;
	logic        prog_done;
	string       cur_test;
	int          errors;
	int          retire_cnt;
	int          total_retires;
	int          tests_run;
	retire_t     exp_r;

	tb_clock clock_i (.o_clk(clk));

	cpu_core dut_i (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_load_valid  (i_load_valid),
		.i_load_addr   (i_load_addr),
		.i_load_data   (i_load_data),
		.o_load_ready  (o_load_ready),
		.i_start       (i_start),
		.o_retire_valid(o_retire_valid),
		.i_retire_ready(i_retire_ready),
		.o_retire_pc   (o_retire_pc),
		.o_wb_en       (o_wb_en),
		.o_wb_reg      (o_wb_reg),
		.o_wb_data     (o_wb_data),
		.o_mem_we      (o_mem_we),
		.o_mem_addr    (o_mem_addr),
		.o_mem_wdata   (o_mem_wdata),
		.o_halt        (o_halt)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ********************
	// Instruction encoders.
	// ********************
	function automatic logic [15:0] enc_imm5(input opcode_e op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_reg(input opcode_e op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] funct);
		return {op, rs, rt, rd, funct};
	endfunction

	function automatic logic [15:0] enc_imm8(input opcode_e op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] enc_disp(input opcode_e op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	function automatic logic [15:0] rotate_left(input logic [15:0] x, input logic [3:0] n);
		return (x << n) | (x >> (16 - n));
	endfunction

	function automatic logic [15:0] rotate_right(input logic [15:0] x, input logic [3:0] n);
		return (x >> n) | (x << (16 - n));
	endfunction

	function automatic logic [15:0] shift_group(input logic [1:0] sel, input logic [15:0] a,
		input logic [3:0] n);
		case (sel)
			2'd0:    return rotate_left(a, n);
			2'd1:    return a << n;
			2'd2:    return rotate_right(a, n);
			default: return a >> n;
		endcase
	endfunction

	// ISA model of one instruction at pc, taken from the model state.
	function automatic retire_t predict_retire(input logic [15:0] pc);
		retire_t     r;
		logic [15:0] ins;
		logic [2:0]  rs;
		logic [2:0]  rt;
		logic [2:0]  rd;
		logic [1:0]  fn;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] se5;
		logic [15:0] ze5;
		logic [15:0] se8;
		logic [15:0] se11;
		logic [16:0] wide;
		logic        cond;
		ins  = m_imem[pc[8:1]];
		rs   = ins[10:8];
		rt   = ins[7:5];
		rd   = ins[4:2];
		fn   = ins[1:0];
		a    = m_regs[rs];
		b    = m_regs[rt];
		se5  = {{11{ins[4]}}, ins[4:0]};
		ze5  = {11'd0, ins[4:0]};
		se8  = {{8{ins[7]}}, ins[7:0]};
		se11 = {{5{ins[10]}}, ins[10:0]};
		cond = 1'b0;
		r = '0;
		r.pc = pc;
		r.next_pc = pc + 16'd2;
		case (opcode_e'(ins[15:11]))
			OP_HALT:  r.halt = 1'b1;
			OP_ADDI:  r.wb_data = a + se5;
			OP_SUBI:  r.wb_data = se5 - a;
			OP_XORI:  r.wb_data = a ^ ze5;
			OP_ANDNI: r.wb_data = a & ~ze5;
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: r.wb_data = shift_group(ins[12:11], a, ins[3:0]);
			OP_ALU_SHIFT: r.wb_data = shift_group(fn, a, b[3:0]);
			OP_ALU_ARITH: begin
				case (fn)
					2'd0:    r.wb_data = a + b;
					2'd1:    r.wb_data = b - a;
					2'd2:    r.wb_data = a ^ b;
					default: r.wb_data = a & ~b;
				endcase
			end
			OP_ST, OP_STU, OP_LD: begin
				r.mem_addr = a + se5;
				r.mem_we   = (ins[15:11] != OP_LD);
				r.mem_wdata = r.mem_we ? b : 16'd0;
				r.wb_data  = (ins[15:11] == OP_LD) ? m_dmem[r.mem_addr[8:1]] : r.mem_addr;
			end
			OP_SLBI: r.wb_data = {a[7:0], ins[7:0]};
			OP_LBI:  r.wb_data = se8;
			OP_BTR: begin
				for (int i = 0; i < 16; i++) begin
					r.wb_data[i] = a[15-i];
				end
			end
			OP_SEQ: r.wb_data = {15'd0, a == b};
			OP_SLT: r.wb_data = {15'd0, $signed(a) < $signed(b)};
			OP_SLE: r.wb_data = {15'd0, $signed(a) <= $signed(b)};
			OP_SCO: begin
				wide = {1'b0, a} + {1'b0, b};
				r.wb_data = {15'd0, wide[16]};
			end
			OP_BEQZ: cond = (a == 16'd0);
			OP_BNEZ: cond = (a != 16'd0);
			OP_BLTZ: cond = a[15];
			OP_BGEZ: cond = !a[15];
			OP_J, OP_JAL: begin
				r.next_pc = pc + 16'd2 + se11;
				r.wb_data = pc + 16'd2;
			end
			OP_JR, OP_JALR: begin
				r.next_pc = a + se8;
				r.wb_data = pc + 16'd2;
			end
			default: begin
			end
		endcase
		if (cond) begin
			r.next_pc = pc + 16'd2 + se8;
		end
		// Destination register per instruction class.
		case (opcode_e'(ins[15:11]))
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI, OP_LD: begin
				r.wb_en  = 1'b1;
				r.wb_reg = rt;
			end
			OP_ALU_SHIFT, OP_ALU_ARITH, OP_BTR, OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				r.wb_en  = 1'b1;
				r.wb_reg = rd;
			end
			OP_STU, OP_SLBI, OP_LBI: begin
				r.wb_en  = 1'b1;
				r.wb_reg = rs;
			end
			OP_JAL, OP_JALR: begin
				r.wb_en  = 1'b1;
				r.wb_reg = 3'd7;
			end
			default: r.wb_data = 16'd0;
		endcase
		return r;
	endfunction

	task automatic compare_value(input string field, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("Fail %s %s at pc %h: expected %h, actual %h", cur_test, field,
				exp_r.pc, expected, actual);
			errors++;
		end
	endtask

	// ********************
	// Comparing process.
	// ********************
	always @(posedge clk) begin
		if (rst_n && o_retire_valid && i_retire_ready) begin
			if (!m_active) begin
				$display("%s: a retire arrived at pc %h after the program ended", cur_test,
					o_retire_pc);
				errors++;
			end else begin
				exp_r = predict_retire(m_pc);
				compare_value("pc", exp_r.pc, o_retire_pc);
				compare_value("halt", {15'd0, exp_r.halt}, {15'd0, o_halt});
				compare_value("wb_en", {15'd0, exp_r.wb_en}, {15'd0, o_wb_en});
				compare_value("mem_we", {15'd0, exp_r.mem_we}, {15'd0, o_mem_we});
				if (exp_r.wb_en) begin
					compare_value("wb_reg", {13'd0, exp_r.wb_reg}, {13'd0, o_wb_reg});
					compare_value("wb_data", exp_r.wb_data, o_wb_data);
					m_regs[exp_r.wb_reg] = exp_r.wb_data;
				end
				if (exp_r.mem_we) begin
					compare_value("mem_addr", exp_r.mem_addr, o_mem_addr);
					compare_value("mem_wdata", exp_r.mem_wdata, o_mem_wdata);
					m_dmem[exp_r.mem_addr[8:1]] = exp_r.mem_wdata;
				end
				m_pc = exp_r.next_pc;
				retire_cnt++;
				total_retires++;
				if (exp_r.halt) begin
					m_active  = 1'b0;
					prog_done = 1'b1;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	task automatic run_program(input string name, input int exp_retires, input bit backpressure);
		int start_err;
		start_err = errors;
		cur_test = name;
		@(negedge clk);
		if (!o_load_ready) begin
			$display("%s: load port not ready before loading", name);
			errors++;
		end
		for (int i = 0; i < prog.size(); i++) begin
			i_load_valid = 1'b1;
			i_load_addr  = 8'(i);
			i_load_data  = prog[i];
			m_imem[i]    = prog[i];
			@(negedge clk);
		end
		i_load_valid = 1'b0;
		retire_cnt = 0;
		prog_done  = 1'b0;
		m_pc       = 16'd0;
		m_active   = 1'b1;
		i_start    = 1'b1;
		i_retire_ready = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		// Ready toggles at random under back-pressure.
		while (!prog_done) begin
			if (backpressure) begin
				rng = xorshift32(rng);
				i_retire_ready = rng[0];
			end
			@(negedge clk);
		end
		i_retire_ready = 1'b1;
		repeat (2) begin
			if (o_retire_valid || !o_load_ready) begin
				$display("%s: core did not return to idle after halt", name);
				errors++;
			end
			@(negedge clk);
		end
		if (retire_cnt != exp_retires) begin
			$display("Fail %s retire count: expected %0d, actual %0d", name, exp_retires,
				retire_cnt);
			errors++;
		end
		$display("test %s: %0d retires, %0d errors", name, retire_cnt, errors - start_err);
		tests_run++;
		prog.delete();
	endtask

	// ********************
	// Programs.
	// ********************
	task automatic build_arith();
		prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'h35));
		prog.push_back(enc_imm8(OP_LBI, 3'd2, 8'hf9));
		prog.push_back(enc_imm5(OP_ADDI, 3'd1, 3'd3, 5'd5));
		prog.push_back(enc_imm5(OP_SUBI, 3'd2, 3'd4, 5'd3));
		prog.push_back(enc_imm5(OP_XORI, 3'd1, 3'd5, 5'h1f));
		prog.push_back(enc_imm5(OP_ANDNI, 3'd1, 3'd6, 5'h05));
		for (int f = 0; f < 4; f++) begin
			prog.push_back(enc_reg(OP_ALU_ARITH, 3'd1, 3'd2, 3'(f + 3), 2'(f)));
		end
		prog.push_back(enc_disp(OP_HALT, 11'd0));
	endtask

	task automatic build_shift();
		prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'h5a));
		prog.push_back(enc_imm8(OP_SLBI, 3'd1, 8'hc3));
		prog.push_back(enc_imm5(OP_ROLI, 3'd1, 3'd2, 5'd5));
		prog.push_back(enc_imm5(OP_SLLI, 3'd1, 3'd3, 5'd4));
		prog.push_back(enc_imm5(OP_RORI, 3'd1, 3'd4, 5'd3));
		prog.push_back(enc_imm5(OP_SRLI, 3'd1, 3'd5, 5'd9));
		prog.push_back(enc_imm8(OP_LBI, 3'd6, 8'h07));
		for (int f = 0; f < 4; f++) begin
			prog.push_back(enc_reg(OP_ALU_SHIFT, 3'd1, 3'd6, 3'(f + 2), 2'(f)));
		end
		prog.push_back(enc_reg(OP_BTR, 3'd1, 3'd0, 3'd7, 2'd0));
		prog.push_back(enc_imm8(OP_LBI, 3'd6, 8'hff));
		prog.push_back(enc_reg(OP_ALU_SHIFT, 3'd1, 3'd6, 3'd3, 2'd1));
		prog.push_back(enc_imm5(OP_SRLI, 3'd1, 3'd5, 5'h1f));
		prog.push_back(enc_imm5(OP_ROLI, 3'd1, 3'd2, 5'h10));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
	endtask

	task automatic build_mem_sets();
		prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'h40));
		prog.push_back(enc_imm8(OP_LBI, 3'd2, 8'h12));
		prog.push_back(enc_imm8(OP_SLBI, 3'd2, 8'h34));
		prog.push_back(enc_imm5(OP_ST, 3'd1, 3'd2, 5'd4));
		prog.push_back(enc_imm5(OP_LD, 3'd1, 3'd3, 5'd4));
		prog.push_back(enc_imm5(OP_STU, 3'd1, 3'd2, 5'h1e));
		prog.push_back(enc_imm5(OP_LD, 3'd1, 3'd4, 5'd0));
		// 0x7fff and 0x8000 for the signed boundary.
		prog.push_back(enc_imm8(OP_LBI, 3'd5, 8'h7f));
		prog.push_back(enc_imm8(OP_SLBI, 3'd5, 8'hff));
		prog.push_back(enc_imm8(OP_LBI, 3'd6, 8'h80));
		prog.push_back(enc_imm8(OP_SLBI, 3'd6, 8'h00));
		prog.push_back(enc_reg(OP_SLT, 3'd6, 3'd5, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SLT, 3'd5, 3'd6, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SLE, 3'd5, 3'd5, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SLE, 3'd6, 3'd5, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SEQ, 3'd5, 3'd6, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SEQ, 3'd5, 3'd5, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SCO, 3'd5, 3'd6, 3'd7, 2'd0));
		prog.push_back(enc_reg(OP_SCO, 3'd6, 3'd6, 3'd7, 2'd0));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
	endtask

	task automatic build_control();
		prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'h00));
		prog.push_back(enc_imm8(OP_BEQZ, 3'd1, 8'd2));
		prog.push_back(enc_imm8(OP_LBI, 3'd2, 8'h11));
		prog.push_back(enc_imm8(OP_BNEZ, 3'd1, 8'd2));
		prog.push_back(enc_imm8(OP_LBI, 3'd3, 8'hff));
		prog.push_back(enc_imm8(OP_BLTZ, 3'd3, 8'd2));
		prog.push_back(enc_imm8(OP_LBI, 3'd2, 8'h22));
		prog.push_back(enc_imm8(OP_BGEZ, 3'd3, 8'd2));
		prog.push_back(enc_imm8(OP_BGEZ, 3'd1, 8'd2));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_disp(OP_JAL, 11'd2));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_imm8(OP_LBI, 3'd4, 8'h20));
		prog.push_back(enc_imm8(OP_JR, 3'd4, 8'h00));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_imm8(OP_JALR, 3'd4, 8'h08));
		repeat (3) prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_disp(OP_J, 11'd2));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_imm8(OP_BLTZ, 3'd1, 8'd2));
		prog.push_back(enc_imm8(OP_BEQZ, 3'd3, 8'd2));
		prog.push_back(enc_imm8(OP_BNEZ, 3'd3, 8'd2));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
	endtask

	task automatic build_random();
		opcode_e ops [16];
		ops = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI,
			OP_ALU_ARITH, OP_ALU_SHIFT, OP_LBI, OP_SLBI, OP_BTR, OP_SEQ, OP_SLT, OP_SCO};
		for (int i = 0; i < RAND_LEN; i++) begin
			rng = xorshift32(rng);
			prog.push_back(enc_disp(ops[rng[3:0]], rng[26:16]));
		end
		prog.push_back(enc_disp(OP_HALT, 11'd0));
	endtask

	initial begin
		rst_n          = 1'b0;
		i_load_valid   = 1'b0;
		i_load_addr    = 8'd0;
		i_load_data    = 16'd0;
		i_start        = 1'b0;
		i_retire_ready = 1'b0;
		rng            = 32'h4b41_0298;
		prog_done      = 1'b0;
		m_active       = 1'b0;
		m_pc           = 16'd0;
		errors         = 0;
		retire_cnt     = 0;
		total_retires  = 0;
		tests_run      = 0;
		cur_test       = "reset";
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = 16'd0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		build_arith();
		run_program("arith", 11, 1'b0);
		build_shift();
		run_program("shift", 17, 1'b0);
		build_mem_sets();
		run_program("mem_sets", 20, 1'b0);
		build_control();
		run_program("control", 16, 1'b0);
		build_random();
		run_program("backpressure", RAND_LEN + 1, 1'b1);
		prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'h09));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		run_program("halt", 2, 1'b0);
		prog.push_back(enc_imm5(OP_ADDI, 3'd1, 3'd2, 5'd1));
		prog.push_back(enc_disp(OP_HALT, 11'd0));
		run_program("reload", 2, 1'b0);

		$display("%0d tests, %0d retires checked, %0d errors", tests_run, total_retires, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* sources.f */
source/isa_pkg.sv
source/ctrl_pkg.sv
source/control.sv
source/reg_file.sv
source/alu.sv
source/branch_unit.sv
source/cpu_core.sv
verif/tb_clock.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f sources.f -o cpu_sim

out=$(./obj_dir/cpu_sim)
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
	exit 0
fi
exit 1
